// File: cpu.f
rtl/cpu_pkg.sv
rtl/control_unit.sv
rtl/register_file.sv
rtl/alu.sv
rtl/pc_counter.sv
rtl/hazard_fsm.sv
rtl/forwarding_unit.sv
rtl/datapath.sv
rtl/unified_ram.sv
rtl/cpu_top.sv
test/cpu_tb.sv

// File: rtl/alu.sv
// combinational ALU for the supported integer operations
`default_nettype none
`timescale 1ns/1ns

module alu import cpu_pkg::*; (
   input  word_t      op1, op2,
   input  logic [4:0] shamt,
   input  aluop_t     alu_op,
   output word_t      res
);

   always_comb begin
      case (alu_op)
         ALU_ADD: res = op1 + op2;
         ALU_SUB: res = op1 - op2;
         ALU_AND: res = op1 & op2;
         ALU_OR:  res = op1 | op2;
         ALU_XOR: res = op1 ^ op2;
         ALU_SLT: res = {31'b0, $signed(op1) < $signed(op2)};
         ALU_SLL: res = op2 << shamt;
         default: res = op2;  // lui, immediate comes in already shifted
      endcase
   end

endmodule

`default_nettype wire

// File: rtl/control_unit.sv
// instruction decoder, turns the ID-stage instruction into the control fields carried down the pipe
`default_nettype none
`timescale 1ns/1ns

module control_unit import cpu_pkg::*; (
   input  word_t      instr,
   output regbits_t   rs, rt, rd,
   output logic [4:0] shamt,
   output logic [15:0] imm16,
   output logic       extop, regwr, memwr, memrd, halt,
   output aluop_t     alu_op,
   output logic [1:0] alu_src,   // 0 reg, 1 imm, 2 imm << 16
   output logic [1:0] regdst,    // 0 rd, 1 rt, 2 ra
   output logic [1:0] memtoreg,  // 0 alu, 1 load, 2 pc+4
   output logic [1:0] pc_src,    // 0 seq, 1 branch, 2 jump
   output logic       branch_ne, branch_eq
);

   assign rs    = instr[25:21];
   assign rt    = instr[20:16];
   assign rd    = instr[15:11];
   assign shamt = instr[10:6];
   assign imm16 = instr[15:0];

   always_comb begin
      // anything not listed falls out as a nop
      extop     = 1'b0;
      regwr     = 1'b0;
      memwr     = 1'b0;
      memrd     = 1'b0;
      halt      = 1'b0;
      alu_op    = ALU_ADD;
      alu_src   = 2'd0;
      regdst    = 2'd0;
      memtoreg  = 2'd0;
      pc_src    = 2'd0;
      branch_ne = 1'b0;
      branch_eq = 1'b0;
      case (opcode_t'(instr[31:26]))
         OP_RTYPE: begin
            regwr = 1'b1;
            case (funct_t'(instr[5:0]))
               FN_ADDU: alu_op = ALU_ADD;
               FN_SUBU: alu_op = ALU_SUB;
               FN_AND:  alu_op = ALU_AND;
               FN_OR:   alu_op = ALU_OR;
               FN_XOR:  alu_op = ALU_XOR;
               FN_SLT:  alu_op = ALU_SLT;
               FN_SLL:  alu_op = ALU_SLL;
               default: regwr = 1'b0;  // unsupported funct
            endcase
         end
         OP_ADDIU, OP_LW: begin
            regwr   = 1'b1;
            regdst  = 2'd1;
            alu_src = 2'd1;
            extop   = 1'b1;
            if (opcode_t'(instr[31:26]) == OP_LW) begin
               memrd    = 1'b1;
               memtoreg = 2'd1;
            end
         end
         OP_ORI: begin
            regwr   = 1'b1;
            regdst  = 2'd1;
            alu_src = 2'd1;
            alu_op  = ALU_OR;
         end
         OP_LUI: begin
            regwr   = 1'b1;
            regdst  = 2'd1;
            alu_src = 2'd2;
            alu_op  = ALU_LUI;
         end
         OP_SW: begin
            memwr   = 1'b1;
            alu_src = 2'd1;
            extop   = 1'b1;
         end
         OP_BEQ, OP_BNE: begin
            extop     = 1'b1;  // signed word offset
            pc_src    = 2'd1;
            branch_eq = (opcode_t'(instr[31:26]) == OP_BEQ);
            branch_ne = (opcode_t'(instr[31:26]) == OP_BNE);
         end
         OP_J:    pc_src = 2'd2;
         OP_JAL: begin
            pc_src   = 2'd2;
            regwr    = 1'b1;
            regdst   = 2'd2;
            memtoreg = 2'd2;
         end
         OP_HALT: halt = 1'b1;
         default: ;
      endcase
   end

endmodule

`default_nettype wire

// File: rtl/cpu_pkg.sv
// shared word types, opcode and alu encodings and memory sizes, imported by the core blocks
`default_nettype none

package cpu_pkg;

   typedef logic [31:0] word_t;     // data and address word
   typedef logic [4:0]  regbits_t;  // register index
   typedef logic [9:0]  ramaddr_t;  // word index into the ram

   localparam word_t    PC_INIT   = 32'h0000_0000;
   localparam int       RAM_WORDS = 1024;
   localparam int       DMEM_WAIT = 1;  // extra cycles per data access
   localparam int       WAIT_W    = $clog2(DMEM_WAIT + 1);
   localparam regbits_t REG_RA    = 5'd31;  // jal link register

   // primary opcodes
   typedef enum logic [5:0] {
      OP_RTYPE = 6'h00,
      OP_J     = 6'h02,
      OP_JAL   = 6'h03,
      OP_BEQ   = 6'h04,
      OP_BNE   = 6'h05,
      OP_ADDIU = 6'h09,
      OP_ORI   = 6'h0d,
      OP_LUI   = 6'h0f,
      OP_LW    = 6'h23,
      OP_SW    = 6'h2b,
      OP_HALT  = 6'h3f
   } opcode_t;

   // r-type function field
   typedef enum logic [5:0] {
      FN_SLL  = 6'h00,
      FN_ADDU = 6'h21,
      FN_SUBU = 6'h23,
      FN_AND  = 6'h24,
      FN_OR   = 6'h25,
      FN_XOR  = 6'h26,
      FN_SLT  = 6'h2a
   } funct_t;

   typedef enum logic [2:0] {
      ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_SLT, ALU_SLL, ALU_LUI
   } aluop_t;

endpackage

`default_nettype wire

// File: rtl/cpu_top.sv
// core top level, joins the datapath to the unified RAM and brings out halt and the boot port
`default_nettype none
`timescale 1ns/1ns

module cpu_top import cpu_pkg::*; (
   input  logic     CLK, nRST,
   output logic     halt,
   input  logic     prog_en, prog_wen,
   input  ramaddr_t prog_addr,
   input  word_t    prog_wdat,
   output word_t    prog_rdat
);

   // core to ram
   word_t imemaddr, imemload, dmemaddr, dmemstore, dmemload;
   logic  imemREN, ihit, dmemREN, dmemWEN, dhit;

   datapath u_datapath (.*);

   unified_ram u_unified_ram (.*);

endmodule

`default_nettype wire

// File: rtl/datapath.sv
// five-stage core datapath, holds the pipeline latches, stage muxes and block wiring
`default_nettype none
`timescale 1ns/1ns

module datapath import cpu_pkg::*; (
   input  logic  CLK, nRST,
   output word_t imemaddr,
   output logic  imemREN,
   input  word_t imemload,
   input  logic  ihit,
   output word_t dmemaddr, dmemstore,
   output logic  dmemREN, dmemWEN,
   input  word_t dmemload,
   input  logic  dhit,
   output logic  halt
);

   // hazard and fetch
   logic pc_en, fd_en, fd_flush, de_en, de_flush, em_en, mw_en, load_use, redirect;
   word_t pc, fd_instr, fd_npc;
   // decode
   regbits_t   id_rs, id_rt, id_rd;
   logic [4:0] id_shamt;
   logic [15:0] id_imm16;
   logic       id_extop, id_regwr, id_memwr, id_memrd, id_halt, id_beq, id_bne;
   aluop_t     id_alu_op;
   logic [1:0] id_alu_src, id_regdst, id_memtoreg, id_pc_src;
   word_t      id_rdat1, id_rdat2, id_imm;
   // ID/EX
   word_t      de_npc, de_rdat1, de_rdat2, de_imm, de_jtarget;
   regbits_t   de_rs, de_rt, de_rd;
   logic [4:0] de_shamt;
   aluop_t     de_alu_op;
   logic [1:0] de_alu_src, de_regdst, de_memtoreg, de_pc_src;
   logic       de_regwr, de_memwr, de_memrd, de_halt, de_beq, de_bne;
   // execute
   logic [1:0] fwd_op1, fwd_op2, pc_sel;
   word_t      ex_op1, ex_op2_fwd, ex_op2, ex_res, br_target;
   regbits_t   ex_wsel;
   logic       br_taken;
   // EX/MEM and MEM/WB
   word_t      em_npc, em_res, em_store, mw_npc, mw_res, mw_load, wb_wdat;
   regbits_t   em_wsel, mw_wsel;
   logic [1:0] em_memtoreg, mw_memtoreg;
   logic       em_regwr, em_memwr, em_memrd, em_halt, mw_regwr, mw_halt;

   control_unit u_control_unit (
      .instr(fd_instr),
      .rs(id_rs), .rt(id_rt), .rd(id_rd), .shamt(id_shamt), .imm16(id_imm16),
      .extop(id_extop), .regwr(id_regwr), .memwr(id_memwr), .memrd(id_memrd),
      .halt(id_halt), .alu_op(id_alu_op), .alu_src(id_alu_src), .regdst(id_regdst),
      .memtoreg(id_memtoreg), .pc_src(id_pc_src), .branch_ne(id_bne), .branch_eq(id_beq)
   );

   register_file u_register_file (
      .CLK, .nRST, .wen(mw_regwr), .wsel(mw_wsel), .rsel1(id_rs), .rsel2(id_rt),
      .wdat(wb_wdat), .rdat1(id_rdat1), .rdat2(id_rdat2)
   );

   alu u_alu (.op1(ex_op1), .op2(ex_op2), .shamt(de_shamt), .alu_op(de_alu_op), .res(ex_res));

   pc_counter u_pc_counter (
      .CLK, .nRST, .pc_en, .pc_src(pc_sel), .branch_target(br_target),
      .jump_target(de_jtarget), .pc
   );

   hazard_fsm u_hazard_fsm (
      .CLK, .nRST, .ihit, .dhit, .dmem_req(em_memrd || em_memwr), .load_use, .redirect,
      .halt_wb(mw_halt), .pc_en, .fd_en, .fd_flush, .de_en, .de_flush, .em_en, .mw_en,
      .halted(halt)
   );

   forwarding_unit u_forwarding_unit (
      .ex_rs(de_rs), .ex_rt(de_rt), .mem_wsel(em_wsel), .wb_wsel(mw_wsel),
      .mem_regwr(em_regwr), .wb_regwr(mw_regwr), .fwd_op1, .fwd_op2
   );

   ////////////////////////////////////////
   // fetch and decode
   ////////////////////////////////////////
   assign imemaddr = pc;
   assign imemREN  = !halt;

   always_ff @(posedge CLK, negedge nRST) begin
      if (!nRST) begin
         fd_instr <= '0;
         fd_npc   <= '0;
      end else if (fd_flush) begin
         fd_instr <= '0;  // all-zero word decodes as a nop
      end else if (fd_en) begin
         fd_instr <= imemload;
         fd_npc   <= pc + 32'd4;
      end
   end

   assign id_imm   = id_extop ? {{16{id_imm16[15]}}, id_imm16} : {16'h0, id_imm16};
   // load in EX feeding the instruction in ID
   assign load_use = de_memrd && de_rt != '0 && (de_rt == id_rs || de_rt == id_rt);

   always_ff @(posedge CLK, negedge nRST) begin
      if (!nRST) begin
         de_regwr    <= 1'b0;
         de_memwr    <= 1'b0;
         de_memrd    <= 1'b0;
         de_halt     <= 1'b0;
         de_beq      <= 1'b0;
         de_bne      <= 1'b0;
         de_pc_src   <= 2'd0;
         de_alu_op   <= ALU_ADD;
         de_alu_src  <= 2'd0;
         de_regdst   <= 2'd0;
         de_memtoreg <= 2'd0;
      end else if (de_flush) begin
         de_regwr  <= 1'b0;
         de_memwr  <= 1'b0;
         de_memrd  <= 1'b0;
         de_halt   <= 1'b0;
         de_beq    <= 1'b0;
         de_bne    <= 1'b0;
         de_pc_src <= 2'd0;
      end else if (de_en) begin
         de_regwr    <= id_regwr;
         de_memwr    <= id_memwr;
         de_memrd    <= id_memrd;
         de_halt     <= id_halt;
         de_beq      <= id_beq;
         de_bne      <= id_bne;
         de_pc_src   <= id_pc_src;
         de_alu_op   <= id_alu_op;
         de_alu_src  <= id_alu_src;
         de_regdst   <= id_regdst;
         de_memtoreg <= id_memtoreg;
      end
   end

   always_ff @(posedge CLK) begin
      if (de_en) begin
         de_npc     <= fd_npc;
         de_rdat1   <= id_rdat1;
         de_rdat2   <= id_rdat2;
         de_imm     <= id_imm;
         de_jtarget <= {fd_npc[31:28], fd_instr[25:0], 2'b00};
         de_rs      <= id_rs;
         de_rt      <= id_rt;
         de_rd      <= id_rd;
         de_shamt   <= id_shamt;
      end
   end

   ////////////////////////////////////////
   // execute
   ////////////////////////////////////////
   always_comb begin
      case (fwd_op1)
         2'd1:    ex_op1 = em_res;
         2'd2:    ex_op1 = wb_wdat;
         default: ex_op1 = de_rdat1;
      endcase
      case (fwd_op2)
         2'd1:    ex_op2_fwd = em_res;
         2'd2:    ex_op2_fwd = wb_wdat;
         default: ex_op2_fwd = de_rdat2;
      endcase
      case (de_alu_src)
         2'd1:    ex_op2 = de_imm;
         2'd2:    ex_op2 = {de_imm[15:0], 16'h0};  // lui
         default: ex_op2 = ex_op2_fwd;
      endcase
      case (de_regdst)
         2'd1:    ex_wsel = de_rt;
         2'd2:    ex_wsel = REG_RA;
         default: ex_wsel = de_rd;
      endcase
   end

   // branches resolve here on forwarded operands
   assign br_taken  = (de_beq && ex_op1 == ex_op2_fwd) || (de_bne && ex_op1 != ex_op2_fwd);
   assign br_target = de_npc + {de_imm[29:0], 2'b00};
   assign pc_sel    = (de_pc_src == 2'd2) ? 2'd2 : (br_taken ? 2'd1 : 2'd0);
   assign redirect  = (pc_sel != 2'd0);

   ////////////////////////////////////////
   // memory and write back
   ////////////////////////////////////////
   always_ff @(posedge CLK, negedge nRST) begin
      if (!nRST) begin
         em_regwr    <= 1'b0;
         em_memwr    <= 1'b0;
         em_memrd    <= 1'b0;
         em_halt     <= 1'b0;
         em_memtoreg <= 2'd0;
         mw_regwr    <= 1'b0;
         mw_halt     <= 1'b0;
         mw_memtoreg <= 2'd0;
      end else begin
         if (em_en) begin
            em_regwr    <= de_regwr;
            em_memwr    <= de_memwr;
            em_memrd    <= de_memrd;
            em_halt     <= de_halt;
            em_memtoreg <= de_memtoreg;
         end
         if (mw_en) begin
            mw_regwr    <= em_regwr;
            mw_halt     <= em_halt;
            mw_memtoreg <= em_memtoreg;
         end
      end
   end

   always_ff @(posedge CLK) begin
      if (em_en) begin
         em_npc   <= de_npc;
         em_res   <= ex_res;
         em_store <= ex_op2_fwd;
         em_wsel  <= ex_wsel;
      end
      if (mw_en) begin
         mw_npc  <= em_npc;
         mw_res  <= em_res;
         mw_load <= dmemload;
         mw_wsel <= em_wsel;
      end
   end

   assign dmemaddr  = em_res;
   assign dmemstore = em_store;
   assign dmemREN   = em_memrd;
   assign dmemWEN   = em_memwr;

   always_comb begin
      case (mw_memtoreg)
         2'd1:    wb_wdat = mw_load;
         2'd2:    wb_wdat = mw_npc;  // jal link
         default: wb_wdat = mw_res;
      endcase
   end

endmodule

`default_nettype wire

// File: rtl/forwarding_unit.sv
// picks the EX operand sources from EX/MEM or MEM/WB results
`default_nettype none
`timescale 1ns/1ns

module forwarding_unit import cpu_pkg::*; (
   input  regbits_t   ex_rs, ex_rt, mem_wsel, wb_wsel,
   input  logic       mem_regwr, wb_regwr,
   output logic [1:0] fwd_op1, fwd_op2  // 0 latch, 1 EX/MEM, 2 MEM/WB
);

   // youngest writer wins
   function automatic logic [1:0] pick(input regbits_t src);
      logic [1:0] sel;
      sel = 2'd0;
      if (mem_regwr && mem_wsel != '0 && mem_wsel == src)
         sel = 2'd1;
      else if (wb_regwr && wb_wsel != '0 && wb_wsel == src)
         sel = 2'd2;
      return sel;
   endfunction

   assign fwd_op1 = pick(ex_rs);
   assign fwd_op2 = pick(ex_rt);

endmodule

`default_nettype wire

// File: rtl/hazard_fsm.sv
// pipeline hazard controller that drives latch enables and flushes for waits, stalls, redirects and halt
`default_nettype none
`timescale 1ns/1ns

module hazard_fsm (
   input  logic CLK, nRST,
   input  logic ihit, dhit, dmem_req,
   input  logic load_use, redirect, halt_wb,
   output logic pc_en, fd_en, fd_flush, de_en, de_flush, em_en, mw_en,
   output logic halted
);

   typedef enum logic [1:0] {HZ_RUN, HZ_DWAIT, HZ_HALTED} hz_state_t;

   hz_state_t state, next_state;
   logic      dstall;

   assign dstall = dmem_req && !dhit;  // data access still outstanding
   assign halted = (state == HZ_HALTED);

   always_ff @(posedge CLK, negedge nRST) begin
      if (!nRST)
         state <= HZ_RUN;
      else
         state <= next_state;
   end

   always_comb begin
      next_state = state;
      case (state)
         HZ_RUN:   if (dstall) next_state = HZ_DWAIT;
         HZ_DWAIT: if (dhit) next_state = HZ_RUN;
         default:  next_state = HZ_HALTED;  // stays until reset
      endcase
      if (halt_wb)
         next_state = HZ_HALTED;
   end

   ////////////////////////////////////////
   // enables and flushes
   ////////////////////////////////////////
   always_comb begin
      pc_en    = 1'b0;
      fd_en    = 1'b0;
      fd_flush = 1'b0;
      de_en    = 1'b0;
      de_flush = 1'b0;
      em_en    = 1'b0;
      mw_en    = 1'b0;
      // the pipe moves in HZ_RUN without a data stall and in HZ_DWAIT on dhit
      if ((state == HZ_RUN && !dstall) || (state == HZ_DWAIT && dhit)) begin
         de_en = 1'b1;
         em_en = 1'b1;
         mw_en = 1'b1;
         if (redirect) begin
            pc_en    = 1'b1;  // take target and kill IF and ID
            fd_flush = 1'b1;
            de_flush = 1'b1;
         end else if (load_use) begin
            de_flush = 1'b1;  // bubble into EX while PC and IF/ID hold
         end else if (!ihit) begin
            fd_flush = 1'b1;
         end else begin
            pc_en = 1'b1;
            fd_en = 1'b1;
         end
      end
   end

endmodule

`default_nettype wire

// File: rtl/pc_counter.sv
// program counter register with next-address select for sequential, branch and jump
`default_nettype none
`timescale 1ns/1ns

module pc_counter import cpu_pkg::*; (
   input  logic       CLK, nRST, pc_en,
   input  logic [1:0] pc_src,
   input  word_t      branch_target, jump_target,
   output word_t      pc
);

   word_t next_pc;

   always_comb begin
      case (pc_src)
         2'd1:    next_pc = branch_target;
         2'd2:    next_pc = jump_target;
         default: next_pc = pc + 32'd4;
      endcase
   end

   always_ff @(posedge CLK, negedge nRST) begin
      if (!nRST)
         pc <= PC_INIT;
      else if (pc_en)
         pc <= next_pc;
   end

endmodule

`default_nettype wire

// File: rtl/register_file.sv
// 32 x 32 register file with write-through reads, register zero reads as zero
`default_nettype none
`timescale 1ns/1ns

module register_file import cpu_pkg::*; (
   input  logic     CLK, nRST,
   input  logic     wen,
   input  regbits_t wsel, rsel1, rsel2,
   input  word_t    wdat,
   output word_t    rdat1, rdat2
);

   word_t regs [32];

   always_ff @(posedge CLK, negedge nRST) begin
      if (!nRST)
         regs <= '{default: '0};
      else if (wen && wsel != '0)
         regs[wsel] <= wdat;
   end

   // same-cycle write shows up on the read side, WB to ID needs no forward
   assign rdat1 = (rsel1 == '0) ? '0 : (wen && wsel == rsel1) ? wdat : regs[rsel1];
   assign rdat2 = (rsel2 == '0) ? '0 : (wen && wsel == rsel2) ? wdat : regs[rsel2];

endmodule

`default_nettype wire

// File: rtl/unified_ram.sv
// single-port unified program and data RAM with data wait states and a boot programming port
`default_nettype none
`timescale 1ns/1ns

module unified_ram import cpu_pkg::*; (
   input  logic     CLK, nRST,
   input  logic     imemREN,
   input  word_t    imemaddr,
   output word_t    imemload,
   output logic     ihit,
   input  logic     dmemREN, dmemWEN,
   input  word_t    dmemaddr, dmemstore,
   output word_t    dmemload,
   output logic     dhit,
   input  logic     prog_en, prog_wen,
   input  ramaddr_t prog_addr,
   input  word_t    prog_wdat,
   output word_t    prog_rdat
);

   word_t             mem [RAM_WORDS];
   ramaddr_t          iidx, didx;
   logic [WAIT_W-1:0] wait_cnt;
   logic              dreq;

   assign iidx = imemaddr[11:2];
   assign didx = dmemaddr[11:2];

   // data side has priority, programming port shuts out the core
   assign dreq = (dmemREN || dmemWEN) && !prog_en;
   assign dhit = dreq && (wait_cnt == WAIT_W'(DMEM_WAIT));
   assign ihit = imemREN && !dmemREN && !dmemWEN && !prog_en;

   assign imemload  = mem[iidx];
   assign dmemload  = mem[didx];
   assign prog_rdat = mem[prog_addr];

   always_ff @(posedge CLK, negedge nRST) begin
      if (!nRST)
         wait_cnt <= '0;
      else if (!dreq || dhit)
         wait_cnt <= '0;  // next access starts a fresh count
      else
         wait_cnt <= wait_cnt + 1'b1;
   end

   always_ff @(posedge CLK) begin
      if (prog_en && prog_wen)
         mem[prog_addr] <= prog_wdat;
      else if (dhit && dmemWEN)
         mem[didx] <= dmemstore;  // store lands on the dhit cycle
   end

endmodule

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
# builds the core testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timing --top-module cpu_tb -f cpu.f -o Vcpu_tb
if [ $? -ne 0 ]; then
   echo "verilator build failed"
   exit 1
fi

./obj_dir/Vcpu_tb > sim.log 2>&1
if [ $? -ne 0 ]; then
   cat sim.log
   echo "simulation exited with an error"
   exit 1
fi

cat sim.log

if grep -q "STATUS: FAIL" sim.log; then
   exit 1
fi
if ! grep -q "STATUS: PASS" sim.log; then
   echo "no pass status in log"
   exit 1
fi
exit 0

// File: test/cpu_tb.sv
// testbench for the pipelined core, loads programs through the boot port and checks the data region
`default_nettype none
`timescale 1ns/1ns

module cpu_tb import cpu_pkg::*; ();

   typedef word_t prog_t [512];
   typedef word_t data_t [64];

   logic     CLK, nRST, halt, prog_en, prog_wen;
   ramaddr_t prog_addr;
   word_t    prog_wdat, prog_rdat;

   prog_t prog;
   int    prog_len;
   int    seed = 3673;
   int    tests_run, tests_failed;

   cpu_top u_cpu_top (.*);

   initial begin
      CLK = 1'b0;
      forever #10 CLK = ~CLK;
   end

   ////////////////////////////////////////
   // encoders and helpers
   ////////////////////////////////////////
   function automatic word_t enc_r(funct_t f, regbits_t rs, regbits_t rt, regbits_t rd,
                                   logic [4:0] sh);
      return {OP_RTYPE, rs, rt, rd, sh, f};
   endfunction

   function automatic word_t enc_i(opcode_t op, regbits_t rs, regbits_t rt, logic [15:0] imm);
      return {op, rs, rt, imm};
   endfunction

   function automatic word_t enc_j(opcode_t op, logic [25:0] idx);
      return {op, idx};
   endfunction

   // initial data contents, different for every address
   function automatic word_t fill(int a);
      return word_t'(a) * 32'h0001_0193 ^ 32'h5a5a_0f0f;
   endfunction

   task automatic new_prog();
      for (int i = 0; i < 512; i++)
         prog[i] = '0;
      prog_len = 0;
   endtask

   task automatic emit(word_t w);
      prog[prog_len] = w;
      prog_len++;
   endtask

   task automatic rnd(input int unsigned n, output int unsigned v);
      v = $unsigned($random(seed)) % n;
   endtask

   ////////////////////////////////////////
   // instruction-set reference model
   ////////////////////////////////////////
   function automatic void iss_run(input prog_t p, output data_t d);
      word_t    m [1024];
      word_t    r [32];
      word_t    ins, a, b, imm_s, imm_z, ea;
      regbits_t rs, rt, rd;
      int       pc, steps;
      logic     done;
      for (int i = 0; i < 1024; i++)
         m[i] = (i < 512) ? p[i] : fill(i);
      for (int i = 0; i < 32; i++)
         r[i] = '0;
      pc = 0;
      steps = 0;
      done = 1'b0;
      while (!done && steps < 4000) begin
         ins   = m[pc];
         rs    = ins[25:21];
         rt    = ins[20:16];
         rd    = ins[15:11];
         a     = r[rs];
         b     = r[rt];
         imm_s = {{16{ins[15]}}, ins[15:0]};
         imm_z = {16'h0, ins[15:0]};
         ea    = a + imm_s;
         pc    = pc + 1;  // no delay slot
         case (ins[31:26])
            OP_RTYPE: begin
               case (ins[5:0])
                  FN_ADDU: r[rd] = a + b;
                  FN_SUBU: r[rd] = a - b;
                  FN_AND:  r[rd] = a & b;
                  FN_OR:   r[rd] = a | b;
                  FN_XOR:  r[rd] = a ^ b;
                  FN_SLT:  r[rd] = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                  FN_SLL:  r[rd] = b << ins[10:6];
                  default: ;
               endcase
            end
            OP_ADDIU: r[rt] = a + imm_s;
            OP_ORI:   r[rt] = a | imm_z;
            OP_LUI:   r[rt] = {ins[15:0], 16'h0};
            OP_LW:    r[rt] = m[ea[11:2]];
            OP_SW:    m[ea[11:2]] = b;
            OP_BEQ:   if (a == b) pc = pc + int'($signed(imm_s));
            OP_BNE:   if (a != b) pc = pc + int'($signed(imm_s));
            OP_J:     pc = int'(ins[25:0]);
            OP_JAL: begin
               r[31] = word_t'(pc * 4);
               pc = int'(ins[25:0]);
            end
            OP_HALT:  done = 1'b1;
            default:  ;
         endcase
         r[0] = '0;
         steps++;
      end
      for (int i = 0; i < 64; i++)
         d[i] = m[512 + i];
   endfunction

   ////////////////////////////////////////
   // load, run and compare
   ////////////////////////////////////////
   task automatic load_and_reset();
      @(posedge CLK);
      nRST     <= 1'b0;
      prog_en  <= 1'b1;
      prog_wen <= 1'b1;
      for (int a = 0; a < 576; a++) begin
         @(posedge CLK);
         prog_addr <= ramaddr_t'(a);
         if (a < 512)
            prog_wdat <= prog[a];
         else
            prog_wdat <= fill(a);
      end
      @(posedge CLK);
      prog_wen <= 1'b0;
      prog_en  <= 1'b0;
      repeat (4) @(posedge CLK);
      nRST <= 1'b1;
   endtask

   task automatic run_test(input string name);
      data_t exp;
      int    limit, bad;
      logic  timed_out;
      iss_run(prog, exp);
      load_and_reset();
      limit = 8 * prog_len + 50;
      timed_out = 1'b1;
      bad = 0;
      for (int c = 0; c < limit; c++) begin
         @(negedge CLK);
         if (halt) begin
            timed_out = 1'b0;
            break;
         end
      end
      if (timed_out) begin
         $display("halt never rose in test %s", name);
         bad = 1;
      end else begin
         @(posedge CLK);
         prog_en <= 1'b1;  // core is frozen, port takes the ram
         for (int i = 0; i < 64; i++) begin
            @(posedge CLK);
            prog_addr <= ramaddr_t'(512 + i);
            @(negedge CLK);
            assert (prog_rdat === exp[i]) else begin
               $display("ERROR test %s addr %0d expected %h actual %h",
                        name, 512 + i, exp[i], prog_rdat);
               bad++;
            end
         end
      end
      tests_run++;
      if (bad != 0)
         tests_failed++;
      $display("test %s %s", name, (bad == 0) ? "passed" : "failed");
   endtask

   ////////////////////////////////////////
   // directed programs
   ////////////////////////////////////////
   task automatic build_alu();
      new_prog();
      emit(enc_i(OP_ORI, 5'd0, 5'd1, 16'h0800));   // data base
      emit(enc_i(OP_ADDIU, 5'd0, 5'd2, 16'hfffb)); // -5
      emit(enc_i(OP_ORI, 5'd2, 5'd3, 16'h00f0));  // mem forward
      emit(enc_r(FN_ADDU, 5'd3, 5'd2, 5'd4, 5'd0));
      emit(enc_r(FN_SUBU, 5'd4, 5'd3, 5'd5, 5'd0));
      emit(enc_r(FN_AND, 5'd5, 5'd4, 5'd6, 5'd0));
      emit(enc_r(FN_OR, 5'd6, 5'd2, 5'd7, 5'd0));
      emit(enc_r(FN_XOR, 5'd7, 5'd3, 5'd8, 5'd0));
      emit(enc_r(FN_SLT, 5'd2, 5'd8, 5'd9, 5'd0));  // negative on the left
      emit(enc_r(FN_SLT, 5'd8, 5'd2, 5'd10, 5'd0));
      emit(enc_r(FN_SLL, 5'd0, 5'd9, 5'd11, 5'd5));
      emit(enc_r(FN_ADDU, 5'd11, 5'd8, 5'd12, 5'd0));
      for (int r = 2; r <= 12; r++)
         emit(enc_i(OP_SW, 5'd1, regbits_t'(r), 16'(4 * r)));
      emit(enc_j(OP_HALT, 26'h0));
   endtask

   task automatic build_mem();
      new_prog();
      emit(enc_i(OP_ORI, 5'd0, 5'd1, 16'h0800));
      emit(enc_i(OP_LW, 5'd1, 5'd2, 16'd4));
      emit(enc_r(FN_ADDU, 5'd2, 5'd2, 5'd3, 5'd0));  // load-use
      emit(enc_i(OP_SW, 5'd1, 5'd3, 16'd8));
      emit(enc_i(OP_LW, 5'd1, 5'd4, 16'd8));          // reload
      emit(enc_i(OP_SW, 5'd1, 5'd4, 16'd12));         // load feeds store data
      emit(enc_i(OP_ADDIU, 5'd0, 5'd0, 16'd77));
      emit(enc_i(OP_SW, 5'd1, 5'd0, 16'd16));         // r0 stays zero
      emit(enc_i(OP_LW, 5'd1, 5'd0, 16'd4));
      emit(enc_i(OP_SW, 5'd1, 5'd0, 16'd20));
      emit(enc_i(OP_LW, 5'd1, 5'd5, 16'd12));
      emit(enc_i(OP_LW, 5'd1, 5'd6, 16'd40));
      emit(enc_r(FN_XOR, 5'd5, 5'd6, 5'd7, 5'd0));
      emit(enc_i(OP_SW, 5'd1, 5'd7, 16'd24));
      emit(enc_j(OP_HALT, 26'h0));
   endtask

   task automatic build_branch();
      new_prog();
      emit(enc_i(OP_ORI, 5'd0, 5'd1, 16'h0800));
      emit(enc_i(OP_ADDIU, 5'd0, 5'd2, 16'd7));
      emit(enc_i(OP_ADDIU, 5'd0, 5'd3, 16'd7));
      emit(enc_i(OP_BEQ, 5'd2, 5'd3, 16'd2));   // taken, both operands forwarded
      emit(enc_i(OP_ADDIU, 5'd0, 5'd4, 16'd1)); // shadow
      emit(enc_i(OP_SW, 5'd1, 5'd2, 16'd60));   // shadow
      emit(enc_i(OP_ADDIU, 5'd0, 5'd5, 16'd3));
      emit(enc_i(OP_BNE, 5'd5, 5'd2, 16'd1));   // taken
      emit(enc_i(OP_ADDIU, 5'd0, 5'd6, 16'd9));
      emit(enc_i(OP_BNE, 5'd2, 5'd3, 16'd1));   // not taken
      emit(enc_i(OP_ADDIU, 5'd0, 5'd7, 16'd11));
      emit(enc_i(OP_BEQ, 5'd5, 5'd2, 16'd1));   // not taken
      emit(enc_i(OP_ADDIU, 5'd0, 5'd8, 16'd13));
      for (int r = 4; r <= 8; r++)
         emit(enc_i(OP_SW, 5'd1, regbits_t'(r), 16'(4 * r)));
      emit(enc_j(OP_HALT, 26'h0));
   endtask

   task automatic build_jump();
      new_prog();
      emit(enc_i(OP_ORI, 5'd0, 5'd1, 16'h0800));
      emit(enc_j(OP_J, 26'd4));
      emit(enc_i(OP_ADDIU, 5'd0, 5'd2, 16'd1));  // skipped
      emit(enc_i(OP_ADDIU, 5'd0, 5'd2, 16'd2));  // skipped
      emit(enc_j(OP_JAL, 26'd7));
      emit(enc_i(OP_ADDIU, 5'd0, 5'd3, 16'd5));  // skipped
      emit(enc_i(OP_ADDIU, 5'd0, 5'd3, 16'd6));  // skipped
      emit(enc_i(OP_SW, 5'd1, 5'd31, 16'd0));    // link value
      emit(enc_i(OP_LUI, 5'd0, 5'd4, 16'h1234));
      emit(enc_i(OP_ORI, 5'd4, 5'd4, 16'h5678));
      emit(enc_i(OP_SW, 5'd1, 5'd4, 16'd4));
      emit(enc_i(OP_LUI, 5'd0, 5'd5, 16'hdead));
      emit(enc_i(OP_ORI, 5'd5, 5'd5, 16'hbeef));
      emit(enc_i(OP_SW, 5'd1, 5'd5, 16'd8));
      emit(enc_i(OP_SW, 5'd1, 5'd2, 16'd12));
      emit(enc_i(OP_SW, 5'd1, 5'd3, 16'd16));
      emit(enc_j(OP_HALT, 26'h0));
   endtask

   // r1 holds the data base, r2..r7 are scratch
   task automatic build_random();
      int unsigned k, v, s, t, d, sh;
      funct_t      fn;
      new_prog();
      emit(enc_i(OP_ORI, 5'd0, 5'd1, 16'h0800));
      for (int i = 0; i < 40; i++) begin
         rnd(9, k);
         rnd(6, s);
         rnd(6, t);
         rnd(6, d);
         rnd(65536, v);
         if (k < 4) begin
            rnd(7, sh);
            case (sh)
               0:       fn = FN_ADDU;
               1:       fn = FN_SUBU;
               2:       fn = FN_AND;
               3:       fn = FN_OR;
               4:       fn = FN_XOR;
               5:       fn = FN_SLT;
               default: fn = FN_SLL;
            endcase
            emit(enc_r(fn, regbits_t'(s + 2), regbits_t'(t + 2), regbits_t'(d + 2),
                       (fn == FN_SLL) ? 5'(v) : 5'd0));
         end else if (k == 4) begin
            emit(enc_i(OP_ADDIU, regbits_t'(s + 2), regbits_t'(t + 2), 16'(v)));
         end else if (k == 5) begin
            emit(enc_i((v[0]) ? OP_LUI : OP_ORI, regbits_t'(s + 2), regbits_t'(t + 2),
                       16'(v)));
         end else if (k == 6 || k == 7) begin
            emit(enc_i((k == 6) ? OP_LW : OP_SW, 5'd1, regbits_t'(t + 2),
                       16'(4 * (v % 64))));
         end else begin
            emit(enc_i((v[0]) ? OP_BEQ : OP_BNE, regbits_t'(s + 2), regbits_t'(t + 2),
                       16'(1 + v % 3)));  // forward only
         end
      end
      for (int r = 2; r <= 7; r++)
         emit(enc_i(OP_SW, 5'd1, regbits_t'(r), 16'(4 * (56 + r))));
      emit(enc_j(OP_HALT, 26'h0));
   endtask

   initial begin
      nRST      = 1'b0;
      prog_en   = 1'b0;
      prog_wen  = 1'b0;
      prog_addr = '0;
      prog_wdat = '0;
      tests_run = 0;
      tests_failed = 0;

      build_alu();
      run_test("alu_chain");
      build_mem();
      run_test("load_store");
      build_branch();
      run_test("branches");
      build_jump();
      run_test("jumps_lui");
      for (int n = 0; n < 5; n++) begin
         build_random();
         run_test($sformatf("random_%0d", n));
      end

      $display("%0d tests run, %0d passed, %0d failed",
               tests_run, tests_run - tests_failed, tests_failed);
      if (tests_failed == 0)
         $display("STATUS: PASS");
      else
         $display("STATUS: FAIL");
      $finish;
   end

endmodule

`default_nettype wire
